// File: source/clkmeas_defines.svh
// shared widths, register map and reset defaults of the clock monitor, included by RTL and testbench
`ifndef CLKMEAS_DEFINES_SVH
`define CLKMEAS_DEFINES_SVH

// width of the period and high-time counters, in clk_int cycles
`define CLKMEAS_CNT_W 16

// settling periods discarded after enable, reset value of ctrl.skip_count
`define CLKMEAS_SKIP_DEFAULT 4'd2

// shortest period measured without loss
// must stay above the divider latency of 18 cycles
`define CLKMEAS_MIN_PERIOD 20

// wishbone word addresses
`define CLKMEAS_ADR_CTRL   2'd0
`define CLKMEAS_ADR_RESULT 2'd1
`define CLKMEAS_ADR_DUTY   2'd2
`define CLKMEAS_ADR_STATUS 2'd3

// width of the duty fraction, duty = high * 256 / period
`define CLKMEAS_DUTY_W 8

`endif

// File: source/clkmeas_pkg.sv
// register and result types of the clock monitor, referenced by scoped name from the RTL
`default_nettype none

`include "clkmeas_defines.svh"

package clkmeas_pkg;

    // CTRL word, enable in bit 0
    typedef struct packed {
        logic [25:0] spare;
        logic [3:0]  skip_count;
        logic        invert;
        logic        enable;
    } ctrl_t;

    // split view of the RESULT word
    typedef struct packed {
        logic [`CLKMEAS_CNT_W-1:0] period;
        logic [`CLKMEAS_CNT_W-1:0] high;
    } result_fields_t;

    // RESULT word
    // raw on the bus side, fields when a measurement is loaded
    typedef union packed {
        logic [31:0]    raw;
        result_fields_t f;
    } result_u;

    // STATUS word, sticky flags in the low bits
    // count sits in the second byte so it reads as a plain byte
    typedef struct packed {
        logic [15:0] spare_hi;
        logic [7:0]  count;
        logic [4:0]  spare_lo;
        logic        missed;
        logic        overflow;
        logic        valid;
    } status_t;

endpackage

`default_nettype wire

// File: source/meas_if.sv
// bundle carrying one finished measurement from the duty divider to the register block
`timescale 1ns/1ps
`default_nettype none

`include "clkmeas_defines.svh"

interface meas_if;

    // one-cycle pulse, payload below is stable while it is high
    logic                       valid;
    // one-cycle pulse, a start was dropped while the divider was busy
    logic                       missed;
    // period and high time in clk_int cycles
    logic [`CLKMEAS_CNT_W-1:0]  period;
    logic [`CLKMEAS_CNT_W-1:0]  high;
    // duty as a fraction of 256
    logic [`CLKMEAS_DUTY_W-1:0] duty;

    // divider side
    modport source (
        output valid,
        output missed,
        output period,
        output high,
        output duty
    );

    // register side, no back-pressure
    modport sink (
        input valid,
        input missed,
        input period,
        input high,
        input duty
    );

endinterface

`default_nettype wire

// File: source/edge_sampler.sv
// input stage that brings meas_clk into the clk_int domain and turns its edges into pulses
`timescale 1ns/1ps
`default_nettype none

module edge_sampler (
    input  wire  clk_int,
    input  wire  reset,
    input  wire  meas_clk,
    input  wire  invert,
    output logic rise,
    output logic fall
);

    // two-flop synchronizer, meas_clk is asynchronous
    logic sync_ff1;
    logic sync_ff2;
    // previous sample after inversion
    logic level_q;
    // synchronized level with optional inversion
    logic level;

    // invert swaps high and low time, stands in for the old dir setting
    assign level = sync_ff2 ^ invert;

    always_ff @(posedge clk_int) begin
        if (reset) begin
            sync_ff1 <= 1'b0;
            sync_ff2 <= 1'b0;
            level_q  <= 1'b0;
            rise     <= 1'b0;
            fall     <= 1'b0;
        end else begin
            sync_ff1 <= meas_clk;
            sync_ff2 <= sync_ff1;
            level_q  <= level;
            // registered pulses
            // third flop after the raw edge
            rise     <= level & ~level_q;
            fall     <= ~level & level_q;
        end
    end

endmodule

`default_nettype wire

// File: source/period_counter.sv
// counts clk_int cycles per meas_clk period and high phase, and hands each settled period on
`timescale 1ns/1ps
`default_nettype none

`include "clkmeas_defines.svh"

module period_counter (
    input  wire                        clk_int,
    input  wire                        reset,
    input  wire                        enable,
    input  wire  [3:0]                 skip_count,
    input  wire                        rise,
    input  wire                        fall,
    output logic                       start,
    output logic [`CLKMEAS_CNT_W-1:0]  period,
    output logic [`CLKMEAS_CNT_W-1:0]  high,
    output logic                       overflow
);

    localparam int CNT_W = `CLKMEAS_CNT_W;

    // cycles since the last rise, 1 in the cycle after it
    logic [CNT_W-1:0] cnt;
    // count captured at the last fall
    logic [CNT_W-1:0] high_lat;
    // a rise has opened the count
    logic             armed;
    // counter stuck at all ones, waiting for a rise
    logic             sat;
    // periods thrown away since enable
    logic [3:0]       skipped;
    logic             settled;

    assign settled = (skipped >= skip_count);

    // start in the cycle of the rise that closes a good period
    assign start  = enable & rise & armed & ~sat & settled;
    assign period = cnt;
    assign high   = high_lat;

    always_ff @(posedge clk_int) begin
        // dropping enable restarts settling
        if (reset || !enable) begin
            cnt      <= '0;
            armed    <= 1'b0;
            sat      <= 1'b0;
            skipped  <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= 1'b0;
            if (rise) begin
                // every rise opens a fresh period
                cnt   <= CNT_W'(1);
                armed <= 1'b1;
                sat   <= 1'b0;
                // a full period that is still settling is only counted
                if (armed && !sat && !settled) begin
                    skipped <= skipped + 4'd1;
                end
            end else if (armed && !sat) begin
                if (cnt == '1) begin
                    // too slow or stopped
                    // flag once, then wait for the next rise
                    sat      <= 1'b1;
                    overflow <= 1'b1;
                end else begin
                    cnt <= cnt + CNT_W'(1);
                end
            end
        end
    end

    // high time, rise to fall
    always_ff @(posedge clk_int) begin
        if (fall) begin
            high_lat <= cnt;
        end
    end

endmodule

`default_nettype wire

// File: source/duty_divider.sv
// serial divider that turns high and period counts into a duty fraction of 256 and publishes it
`timescale 1ns/1ps
`default_nettype none

`include "clkmeas_defines.svh"

module duty_divider (
    input  wire                       clk_int,
    input  wire                       reset,
    input  wire                       start,
    input  wire  [`CLKMEAS_CNT_W-1:0] period,
    input  wire  [`CLKMEAS_CNT_W-1:0] high,
    meas_if.source                    result
);

    localparam int W      = `CLKMEAS_CNT_W;
    localparam int DUTY_W = `CLKMEAS_DUTY_W;
    // step value of the finish cycle, after 16 iterations
    localparam logic [4:0] LAST_STEP = 5'd16;

    logic              busy;
    logic [4:0]        step;
    logic [W-1:0]      per_l;
    logic [W-1:0]      high_l;
    logic [W-1:0]      rem;
    // fraction high / period with 16 bits, top byte is the duty
    logic [W-1:0]      quo;
    logic [DUTY_W-1:0] duty_q;
    logic              valid_q;
    logic              missed_q;
    // shifted remainder minus divisor, msb set when negative
    logic [W+1:0]      trial;

    assign trial = {1'b0, rem, 1'b0} - {2'b00, per_l};

    always_ff @(posedge clk_int) begin
        if (reset) begin
            busy     <= 1'b0;
            step     <= '0;
            valid_q  <= 1'b0;
            missed_q <= 1'b0;
        end else begin
            valid_q  <= 1'b0;
            // no queue, a start during a run is lost
            missed_q <= start & busy;
            if (!busy) begin
                if (start) begin
                    busy <= 1'b1;
                    step <= '0;
                end
            end else if (step == LAST_STEP) begin
                busy    <= 1'b0;
                valid_q <= 1'b1;
            end else begin
                step <= step + 5'd1;
            end
        end
    end

    // restoring shift-subtract
    // high < period, so the integer part is zero and rem starts at high
    always_ff @(posedge clk_int) begin
        if (!busy && start) begin
            per_l  <= period;
            high_l <= high;
            rem    <= high;
            quo    <= '0;
        end else if (busy && step != LAST_STEP) begin
            if (!trial[W+1]) begin
                rem <= trial[W-1:0];
                quo <= {quo[W-2:0], 1'b1};
            end else begin
                rem <= {rem[W-2:0], 1'b0};
                quo <= {quo[W-2:0], 1'b0};
            end
        end else if (busy) begin
            // floor of the 16-bit fraction, then keep the top byte
            duty_q <= quo[W-1 -: DUTY_W];
        end
    end

    assign result.valid  = valid_q;
    assign result.missed = missed_q;
    assign result.period = per_l;
    assign result.high   = high_l;
    assign result.duty   = duty_q;

endmodule

`default_nettype wire

// File: source/wb_meas_regs.sv
// wishbone classic slave holding control, last result, duty and sticky status of the monitor
`timescale 1ns/1ps
`default_nettype none

`include "clkmeas_defines.svh"

module wb_meas_regs (
    input  wire         clk_int,
    input  wire         reset,
    input  wire         wb_cyc,
    input  wire         wb_stb,
    input  wire         wb_we,
    input  wire  [1:0]  wb_adr,
    input  wire  [31:0] wb_dat_w,
    input  wire         overflow,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    output logic        enable,
    output logic        invert,
    output logic [3:0]  skip_count,
    meas_if.sink        result
);

    clkmeas_pkg::ctrl_t   ctrl_q;
    clkmeas_pkg::ctrl_t   ctrl_wr;
    clkmeas_pkg::result_u result_q;
    clkmeas_pkg::status_t status_w;
    logic [`CLKMEAS_DUTY_W-1:0] duty_q;

    // sticky flags and wrapping measurement count
    logic       valid_s;
    logic       ovf_s;
    logic       missed_s;
    logic [7:0] meas_cnt;

    // request seen and not yet acked
    logic       req;
    logic       wr_en;
    logic       rd_en;
    logic       status_rd;
    logic [31:0] rd_mux;

    assign req       = wb_cyc & wb_stb & ~wb_ack;
    assign wr_en     = req & wb_we;
    assign rd_en     = req & ~wb_we;
    assign status_rd = rd_en & (wb_adr == `CLKMEAS_ADR_STATUS);

    // spare bits read back as zero
    always_comb begin
        ctrl_wr       = clkmeas_pkg::ctrl_t'(wb_dat_w);
        ctrl_wr.spare = '0;
    end

    always_comb begin
        status_w          = '0;
        status_w.valid    = valid_s;
        status_w.overflow = ovf_s;
        status_w.missed   = missed_s;
        status_w.count    = meas_cnt;
    end

    always_comb begin
        case (wb_adr)
            `CLKMEAS_ADR_CTRL:   rd_mux = ctrl_q;
            `CLKMEAS_ADR_RESULT: rd_mux = result_q.raw;
            `CLKMEAS_ADR_DUTY:   rd_mux = {{(32-`CLKMEAS_DUTY_W){1'b0}}, duty_q};
            default:             rd_mux = status_w;
        endcase
    end

    always_ff @(posedge clk_int) begin
        if (reset) begin
            wb_ack              <= 1'b0;
            ctrl_q              <= '0;
            ctrl_q.skip_count   <= `CLKMEAS_SKIP_DEFAULT;
            valid_s             <= 1'b0;
            ovf_s               <= 1'b0;
            missed_s            <= 1'b0;
            meas_cnt            <= '0;
        end else begin
            // one ack per request, the master drops stb after it
            wb_ack <= req;
            if (wr_en && wb_adr == `CLKMEAS_ADR_CTRL) begin
                ctrl_q <= ctrl_wr;
            end
            // read clears, a new event in the same cycle wins
            if (status_rd) begin
                valid_s  <= 1'b0;
                ovf_s    <= 1'b0;
                missed_s <= 1'b0;
            end
            if (result.valid) begin
                valid_s  <= 1'b1;
                meas_cnt <= meas_cnt + 8'd1;
            end
            if (overflow) begin
                ovf_s <= 1'b1;
            end
            if (result.missed) begin
                missed_s <= 1'b1;
            end
        end
    end

    // result loads the cycle after valid
    always_ff @(posedge clk_int) begin
        if (result.valid) begin
            result_q.f.period <= result.period;
            result_q.f.high   <= result.high;
            duty_q            <= result.duty;
        end
        // read data lines up with the ack
        if (rd_en) begin
            wb_dat_r <= rd_mux;
        end
    end

    assign enable     = ctrl_q.enable;
    assign invert     = ctrl_q.invert;
    assign skip_count = ctrl_q.skip_count;

endmodule

`default_nettype wire

// File: source/clkmeas_top.sv
// top level of the clock monitor, meas_clk in and a wishbone classic register port to the host
`timescale 1ns/1ps
`default_nettype none

`include "clkmeas_defines.svh"

module clkmeas_top (
    input  wire         clk_int,
    input  wire         reset,
    input  wire         meas_clk,
    input  wire         wb_cyc,
    input  wire         wb_stb,
    input  wire         wb_we,
    input  wire  [1:0]  wb_adr,
    input  wire  [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack
);

    // control from the register block
    logic                      enable;
    logic                      invert;
    logic [3:0]                skip_count;
    // edge pulses
    logic                      rise;
    logic                      fall;
    // counter to divider
    logic                      start;
    logic [`CLKMEAS_CNT_W-1:0] period;
    logic [`CLKMEAS_CNT_W-1:0] high;
    logic                      overflow;

    // finished measurements, divider to registers
    meas_if meas_bus ();

    edge_sampler u_edge_sampler (
        .clk_int  (clk_int),
        .reset    (reset),
        .meas_clk (meas_clk),
        .invert   (invert),
        .rise     (rise),
        .fall     (fall)
    );

    period_counter u_period_counter (
        .clk_int    (clk_int),
        .reset      (reset),
        .enable     (enable),
        .skip_count (skip_count),
        .rise       (rise),
        .fall       (fall),
        .start      (start),
        .period     (period),
        .high       (high),
        .overflow   (overflow)
    );

    duty_divider u_duty_divider (
        .clk_int (clk_int),
        .reset   (reset),
        .start   (start),
        .period  (period),
        .high    (high),
        .result  (meas_bus.source)
    );

    wb_meas_regs u_wb_meas_regs (
        .clk_int    (clk_int),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .overflow   (overflow),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .enable     (enable),
        .invert     (invert),
        .skip_count (skip_count),
        .result     (meas_bus.sink)
    );

endmodule

`default_nettype wire

// File: verif/clkmeas_sva.sv
// assertions on wishbone handshake, divider latency and reset state that are bound into clkmeas_top
`timescale 1ns/1ps
`default_nettype none

module clkmeas_sva (
    input wire clk_int,
    input wire reset,
    input wire wb_cyc,
    input wire wb_stb,
    input wire wb_ack,
    input wire enable,
    input wire start,
    input wire overflow,
    input wire rise,
    input wire fall,
    input wire valid
);

    // ack comes one cycle after a new request and lasts one cycle
    assert property (@(posedge clk_int) disable iff (reset)
                     $rose(wb_cyc && wb_stb) |=> (wb_ack ##1 !wb_ack))
        else $error("wb_ack not a single cycle right after the request");

    // ack only inside a request
    assert property (@(posedge clk_int) disable iff (reset) wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack raised without wb_cyc and wb_stb");

    // every result comes from a start accepted 18 cycles before
    assert property (@(posedge clk_int) disable iff (reset) valid |-> $past(start, 18))
        else $error("valid without an accepted start 18 cycles earlier");

    // after the first reset edge all control outputs sit low
    assert property (@(posedge clk_int) (reset && $past(reset)) |->
                     !(wb_ack || enable || start || overflow || rise || fall || valid))
        else $error("control output high during reset");

endmodule

`default_nettype wire

// File: verif/clkmeas_tb.sv
// testbench for the clock monitor that replays the stim cases on meas_clk and checks results over wishbone
`timescale 1ns/1ps
`default_nettype none

`include "clkmeas_defines.svh"

module clkmeas_tb;

    localparam int MAX_CASES = 32;
    // words per stim line
    localparam int COLS      = 6;
    localparam int SKIP      = 2;
    // rises and skip count of the counting test
    localparam int RISES     = 8;
    localparam int SKIP_K    = 3;

    logic        clk_int;
    logic        reset;
    logic        meas_clk;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    logic [15:0] stim [0:MAX_CASES*COLS-1];
    int          num_cases;
    int          errors;
    int          limit_cycles;
    logic        limit_ready;
    logic [31:0] lcg_state;

    // meas_clk shape set by set_clock at negedge
    int          gen_high;
    int          gen_low;
    int          gen_rises;    // rises left or -1 to run free
    int          gen_phase;

    initial clk_int = 1'b0;
    always #5 clk_int = ~clk_int;

    clkmeas_top dut (
        .clk_int  (clk_int),
        .reset    (reset),
        .meas_clk (meas_clk),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    bind clkmeas_top clkmeas_sva sva (
        .clk_int  (clk_int),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_ack   (wb_ack),
        .enable   (enable),
        .start    (start),
        .overflow (overflow),
        .rise     (rise),
        .fall     (fall),
        .valid    (meas_bus.valid)
    );

    // meas_clk moves 1 ns after the edge, so its phases are whole clk_int cycles
    always begin : meas_clk_gen
        @(posedge clk_int);
        #1;
        if (meas_clk) begin
            if (gen_phase >= gen_high - 1) begin
                meas_clk  = 1'b0;
                gen_phase = 0;
            end else begin
                gen_phase = gen_phase + 1;
            end
        end else if (gen_phase >= gen_low - 1 && gen_rises != 0) begin
            meas_clk  = 1'b1;
            gen_phase = 0;
            if (gen_rises > 0) begin
                gen_rises = gen_rises - 1;
            end
        end else begin
            gen_phase = gen_phase + 1;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic set_clock(input int h, input int l, input int rises);
        @(negedge clk_int);
        gen_high  = h;
        gen_low   = l;
        gen_rises = rises;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // ack is looked at 1 ns after the edge that registers it
    task automatic wait_ack(output logic ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < 16) begin
            @(posedge clk_int);
            #1;
            ok = wb_ack;
            n  = n + 1;
        end
        if (!ok) begin
            $display("no wb_ack within 16 cycles for address %0d", wb_adr);
            errors++;
        end
    endtask

    // request stays up across the edge that samples ack and drops after it
    task automatic bus_release();
        @(posedge clk_int);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
        logic ok;
        @(posedge clk_int);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        wait_ack(ok);
        bus_release();
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
        logic ok;
        @(posedge clk_int);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_ack(ok);
        data = wb_dat_r;
        bus_release();
    endtask

    // enable in bit 0, invert in bit 1 and skip count in bits 5:2
    task automatic write_ctrl(input logic en, input logic inv, input logic [3:0] skip);
        wb_write(`CLKMEAS_ADR_CTRL, {26'd0, skip, inv, en});
    endtask

    // polls STATUS with random idle gaps until a bit of mask shows up
    task automatic poll_status(input logic [31:0] mask, input int budget,
                               output logic [31:0] st);
        int waited;
        int gap;
        waited = 0;
        st     = '0;
        while ((st & mask) == 0 && waited < budget) begin
            wb_read(`CLKMEAS_ADR_STATUS, st);
            lcg_state = lcg_next(lcg_state);
            gap       = int'(lcg_state[18:16]);
            repeat (gap) @(posedge clk_int);
            waited = waited + gap + 3;
        end
        if ((st & mask) == 0) begin
            $display("STATUS bits %h never set within %0d cycles", mask, budget);
            errors++;
        end
    endtask

    task automatic run_case(input int idx);
        logic [15:0] h;
        logic [15:0] l;
        logic        inv;
        logic [15:0] e_per;
        logic [15:0] e_high;
        logic [7:0]  e_duty;
        logic [31:0] st;
        logic [31:0] word;
        h      = stim[idx*COLS];
        l      = stim[idx*COLS+1];
        inv    = stim[idx*COLS+2][0];
        e_per  = h + l;
        // inversion swaps which half counts as high
        e_high = inv ? l : h;
        e_duty = 8'((32'(e_high) * 32'd256) / 32'(e_per));
        if (stim[idx*COLS+3] !== e_per || stim[idx*COLS+4] !== e_high ||
            stim[idx*COLS+5] !== {8'd0, e_duty}) begin
            $display("stim case %0d: expected columns disagree with the duty rules", idx);
            errors++;
        end
        write_ctrl(1'b0, inv, 4'(SKIP));
        set_clock(int'(h), int'(l), -1);
        // let the new shape settle and any divider run finish
        repeat (2 * int'(e_per) + 30) @(posedge clk_int);
        wb_read(`CLKMEAS_ADR_STATUS, st);
        write_ctrl(1'b1, inv, 4'(SKIP));
        poll_status(32'h1, (SKIP + 4) * int'(e_per) + 200, st);
        wb_read(`CLKMEAS_ADR_RESULT, word);
        check_value("RESULT.period", {16'd0, word[31:16]}, {16'd0, e_per});
        check_value("RESULT.high", {16'd0, word[15:0]}, {16'd0, e_high});
        wb_read(`CLKMEAS_ADR_DUTY, word);
        check_value("DUTY", word, {24'd0, e_duty});
    endtask

    // watchdog sized from the case periods plus the overflow wait
    initial begin : watchdog
        wait (limit_ready);
        repeat (limit_cycles) @(posedge clk_int);
        $display("timeout after %0d cycles, the run did not complete", limit_cycles);
        $display("errors: %0d", errors + 1);
        $display("Finished with errors");
        $finish;
    end

    initial begin : main
        int          sum_p;
        logic [31:0] st;
        logic [7:0]  c0;
        reset       = 1'b1;
        meas_clk    = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        gen_high    = 10;
        gen_low     = 10;
        gen_rises   = 0;
        gen_phase   = 0;
        errors      = 0;
        limit_ready = 1'b0;
        lcg_state   = 32'h59b8_6eea;
        for (int i = 0; i < MAX_CASES * COLS; i++) begin
            stim[i] = '0;
        end
        $readmemh("verif/clkmeas_stim.txt", stim);
        // list ends at the first zero high time
        num_cases = 0;
        sum_p     = 0;
        while (num_cases < MAX_CASES && stim[num_cases*COLS] != 0) begin
            sum_p     = sum_p + int'(stim[num_cases*COLS]) + int'(stim[num_cases*COLS+1]);
            num_cases = num_cases + 1;
        end
        if (num_cases == 0) begin
            $display("stim file holds no cases");
            errors++;
        end
        limit_cycles = 2 * sum_p * (SKIP + 6) + 400 * num_cases + 75000;
        limit_ready  = 1'b1;

        repeat (5) @(posedge clk_int);
        #1;
        reset = 1'b0;

        // clock runs but enable is low after reset
        set_clock(10, 10, -1);
        repeat (100) @(posedge clk_int);
        wb_read(`CLKMEAS_ADR_STATUS, st);
        check_value("STATUS", st, 32'h0);
        wb_read(`CLKMEAS_ADR_CTRL, st);
        check_value("CTRL", st, {26'd0, 4'(`CLKMEAS_SKIP_DEFAULT), 2'b00});

        for (int c = 0; c < num_cases; c++) begin
            run_case(c);
        end

        // half the minimum period so starts arrive while the divider is busy
        write_ctrl(1'b0, 1'b0, 4'(SKIP));
        set_clock(`CLKMEAS_MIN_PERIOD / 4, `CLKMEAS_MIN_PERIOD / 4, -1);
        repeat (60) @(posedge clk_int);
        wb_read(`CLKMEAS_ADR_STATUS, st);
        write_ctrl(1'b1, 1'b0, 4'(SKIP));
        poll_status(32'h4, 400, st);

        // exact number of rises with a larger skip count
        write_ctrl(1'b0, 1'b0, 4'(SKIP_K));
        set_clock(10, 15, 0);
        repeat (100) @(posedge clk_int);
        wb_read(`CLKMEAS_ADR_STATUS, st);
        c0 = st[15:8];
        write_ctrl(1'b1, 1'b0, 4'(SKIP_K));
        set_clock(10, 15, RISES);
        wait (gen_rises == 0);
        repeat (60) @(posedge clk_int);
        wb_read(`CLKMEAS_ADR_STATUS, st);
        check_value("STATUS.count", {24'd0, st[15:8]}, {24'd0, 8'(c0 + RISES - SKIP_K - 1)});

        // meas_clk now stays low and the armed counter runs into saturation
        repeat (65600) @(posedge clk_int);
        wb_read(`CLKMEAS_ADR_STATUS, st);
        check_value("STATUS.overflow", {31'd0, st[1]}, 32'h1);
        wb_read(`CLKMEAS_ADR_STATUS, st);
        check_value("STATUS.overflow", {31'd0, st[1]}, 32'h0);
        write_ctrl(1'b0, 1'b0, 4'(SKIP));

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/clkmeas_stim.txt
// columns: high cycles, low cycles, invert, expected period, expected high time, expected duty
// all values hex, duty is the floor of high time * 256 / period
// invert clear
000a 000a 0 0014 000a 0080
0007 0017 0 001e 0007 003b
0028 000d 0 0035 0028 00c1
0003 0061 0 0064 0003 0007
0096 0032 0 00c8 0096 00c0
014d 029b 0 03e8 014d 0055
0014 0014 0 0028 0014 0080
0009 000b 0 0014 0009 0073
00fa 0006 0 0100 00fa 00fa
// invert set, high time becomes the low half-period
000a 000a 1 0014 000a 0080
0007 0017 1 001e 0017 00c4
0028 000d 1 0035 000d 003e
0003 0061 1 0064 0061 00f8
0096 0032 1 00c8 0032 0040
014d 029b 1 03e8 029b 00aa
0014 0014 1 0028 0014 0080
0009 000b 1 0014 000b 008c
00fa 0006 1 0100 0006 0006

// File: verilog.f
+incdir+source
source/clkmeas_pkg.sv
source/meas_if.sv
source/edge_sampler.sv
source/period_counter.sv
source/duty_divider.sv
source/wb_meas_regs.sv
source/clkmeas_top.sv
verif/clkmeas_sva.sv
verif/clkmeas_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the clock monitor testbench with Verilator, runs it and scans the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module clkmeas_tb -o clkmeas_sim \
    && ./obj_dir/clkmeas_sim 2>&1 | tee sim.log \
    || { echo "SIM: build or run failed"; exit 1; }

grep -q "Finished with errors" sim.log \
    && { echo "SIM: FAIL"; exit 1; } \
    || { echo "SIM: PASS"; exit 0; }
